/* rtl/warp_addr_pkg.sv */
//==========================================================
// Warp address generator shared definitions
// Widths, configuration record and link payloads
//==========================================================
package warp_addr_pkg;

	// Vector and memory dimensionality
	localparam int VDIM = 2;
	localparam int DIM = 3;

	// Field widths
	localparam int WORK_BW = 10;
	localparam int STRIDE_FRAC_BW = 3;
	localparam int STRIDE_BW = 4;
	localparam int DIM_BW = 2;

	// Defaults for the top level parameters
	localparam int N_ICFG_DEFAULT = 4;
	localparam int GLOBAL_ADDR_BW_DEFAULT = 24;
	// Id field of the link payloads, sized for the default config count
	localparam int ID_BW = $clog2(N_ICFG_DEFAULT);

	// One warp configuration
	typedef struct packed {
		logic [VDIM-1:0][STRIDE_FRAC_BW-1:0] bstride_frac;
		logic [VDIM-1:0][STRIDE_BW-1:0] bstride_shamt;
		logic [VDIM-1:0][STRIDE_FRAC_BW-1:0] astride_frac;
		logic [VDIM-1:0][STRIDE_BW-1:0] astride_shamt;
		logic [VDIM-1:0][DIM_BW-1:0] bshuf;
		logic [VDIM-1:0][DIM_BW-1:0] ashuf;
		logic [DIM-1:0][GLOBAL_ADDR_BW_DEFAULT-1:0] mboundary;
	} cfg_t;

	// Looper to offset stage
	typedef struct packed {
		logic [ID_BW-1:0] id;
		logic [GLOBAL_ADDR_BW_DEFAULT-1:0] linear;
		logic [VDIM-1:0][WORK_BW-1:0] bofs;
		logic [VDIM-1:0][WORK_BW-1:0] aofs;
		logic retire;
		logic islast;
	} req_t;

	// Offset stage to output
	typedef struct packed {
		logic [ID_BW-1:0] id;
		logic [GLOBAL_ADDR_BW_DEFAULT-1:0] linear;
		logic [VDIM-1:0][WORK_BW-1:0] bofs;
		logic retire;
		logic islast;
	} res_t;

endpackage

/* rtl/warp_req_if.sv */
//==========================================================
// Request link between looper and offset stage
// rdy/ack handshake with a request payload
//==========================================================
interface warp_req_if;

	// Source raises rdy and holds it with the data
	logic rdy;
	// Transfer happens in the cycle ack is high
	logic ack;
	// Walk point payload
	warp_addr_pkg::req_t data;

	// Looper side
	modport src (
		output rdy,
		output data,
		input ack
	);

	// Offset stage side
	modport dst (
		input rdy,
		input data,
		output ack
	);

endinterface

/* rtl/rdyack_fwd_stage.sv */
//==========================================================
// One-entry forward slice on a rdy/ack link
//==========================================================
module rdyack_fwd_stage #(
	parameter type payload_t = logic
) (
	input  logic     i_clk,
	input  logic     i_arst_n,
	input  logic     i_src_rdy,
	output logic     o_src_ack,
	input  payload_t i_src_data,
	output logic     o_dst_rdy,
	input  logic     i_dst_ack,
	output payload_t o_dst_data
);

	// Entry occupied
	logic full_r;
	// Held payload
	payload_t data_r;

	// Take a new item when empty or while the held one leaves
	assign o_src_ack = i_src_rdy && (!full_r || i_dst_ack);
	assign o_dst_rdy = full_r;
	assign o_dst_data = data_r;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			full_r <= 1'b0;
		end else if (o_src_ack) begin
			full_r <= 1'b1;
		end else if (i_dst_ack) begin
			full_r <= 1'b0;
		end
	end

	// Payload loads only on a source transfer
	always_ff @(posedge i_clk) begin
		if (o_src_ack) begin
			data_r <= i_src_data;
		end
	end

	// A presented item holds until downstream takes it
	a_dst_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_dst_rdy && !i_dst_ack |=> o_dst_rdy && $stable(o_dst_data));

	// Downstream must only ack a presented item
	a_dst_ack_rdy: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_dst_ack |-> o_dst_rdy);

endmodule

/* rtl/nd_shuf_accum.sv */
//==========================================================
// Shuffled accumulate of two vectors into memory dimensions
//==========================================================
module nd_shuf_accum (
	input  logic [warp_addr_pkg::VDIM-1:0][warp_addr_pkg::WORK_BW-1:0] i_addend1,
	input  logic [warp_addr_pkg::VDIM-1:0][warp_addr_pkg::WORK_BW-1:0] i_addend2,
	input  logic [warp_addr_pkg::VDIM-1:0][warp_addr_pkg::DIM_BW-1:0]  i_shuf1,
	input  logic [warp_addr_pkg::VDIM-1:0][warp_addr_pkg::DIM_BW-1:0]  i_shuf2,
	output logic [warp_addr_pkg::DIM-1:0][warp_addr_pkg::WORK_BW-1:0]  o_sum
);

	localparam int VDIM = warp_addr_pkg::VDIM;
	localparam int DIM = warp_addr_pkg::DIM;
	localparam int DIM_BW = warp_addr_pkg::DIM_BW;

	// Each memory dimension collects the entries mapped onto it
	always_comb begin
		for (int d = 0; d < DIM; d++) begin
			// Unnamed dimensions stay at zero
			o_sum[d] = '0;
			for (int i = 0; i < VDIM; i++) begin
				// Block vector contribution
				if (i_shuf1[i] == DIM_BW'(d)) begin
					o_sum[d] = o_sum[d] + i_addend1[i];
				end
				// Alpha vector contribution
				if (i_shuf2[i] == DIM_BW'(d)) begin
					o_sum[d] = o_sum[d] + i_addend2[i];
				end
			end
		end
	end

endmodule

/* rtl/warp_offset_looper.sv */
//==========================================================
// Warp offset looper
// Accepts a command and emits one request per block offset
//==========================================================
module warp_offset_looper #(
	parameter int N_CFG = warp_addr_pkg::N_ICFG_DEFAULT,
	localparam int NCFG_BW = $clog2(N_CFG)
) (
	input  logic i_clk,
	input  logic i_arst_n,
	input  logic i_cmd_rdy,
	output logic o_cmd_ack,
	input  logic [NCFG_BW-1:0] i_cmd_id,
	input  logic [warp_addr_pkg::GLOBAL_ADDR_BW_DEFAULT-1:0] i_cmd_linear,
	input  logic [warp_addr_pkg::VDIM-1:0][warp_addr_pkg::WORK_BW-1:0] i_cmd_aofs,
	input  logic [warp_addr_pkg::VDIM-1:0][warp_addr_pkg::WORK_BW-1:0] i_cmd_bcount,
	input  logic i_cmd_retire,
	warp_req_if.src req
);

	localparam int VDIM = warp_addr_pkg::VDIM;
	localparam int WBW = warp_addr_pkg::WORK_BW;
	localparam int GABW = warp_addr_pkg::GLOBAL_ADDR_BW_DEFAULT;
	localparam int PID_BW = warp_addr_pkg::ID_BW;

	//==========================================================
	// State
	//==========================================================
	// Walk in progress
	logic busy_r;
	// Latched command
	logic [NCFG_BW-1:0] id_r;
	logic [GABW-1:0] linear_r;
	logic [VDIM-1:0][WBW-1:0] aofs_r;
	logic retire_r;
	// Final index per dimension
	logic [VDIM-1:0][WBW-1:0] blast_r;
	// Current block offset and its successor
	logic [VDIM-1:0][WBW-1:0] bofs_r;
	logic [VDIM-1:0][WBW-1:0] bofs_nxt;
	logic carry;
	logic islast_w;
	warp_addr_pkg::req_t req_w;

	// Commands only while idle
	assign o_cmd_ack = i_cmd_rdy && !busy_r;

	//==========================================================
	// Nested counter
	//==========================================================
	// bofs[0] varies fastest
	always_comb begin
		carry = 1'b1;
		for (int d = 0; d < VDIM; d++) begin
			bofs_nxt[d] = bofs_r[d];
			if (carry) begin
				if (bofs_r[d] == blast_r[d]) begin
					bofs_nxt[d] = '0;
				end else begin
					bofs_nxt[d] = bofs_r[d] + 1'b1;
					carry = 1'b0;
				end
			end
		end
	end

	// Last point when every dimension sits at its final index
	always_comb begin
		islast_w = 1'b1;
		for (int d = 0; d < VDIM; d++) begin
			if (bofs_r[d] != blast_r[d]) begin
				islast_w = 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			busy_r <= 1'b0;
			bofs_r <= '0;
		end else if (o_cmd_ack) begin
			busy_r <= 1'b1;
			bofs_r <= '0;
		end else if (req.ack) begin
			// Back to idle as the final request leaves
			if (islast_w) begin
				busy_r <= 1'b0;
			end
			bofs_r <= bofs_nxt;
		end
	end

	// Command capture, zero count behaves as one
	always_ff @(posedge i_clk) begin
		if (o_cmd_ack) begin
			id_r <= i_cmd_id;
			linear_r <= i_cmd_linear;
			aofs_r <= i_cmd_aofs;
			retire_r <= i_cmd_retire;
			for (int d = 0; d < VDIM; d++) begin
				blast_r[d] <= (i_cmd_bcount[d] == '0) ? '0 : i_cmd_bcount[d] - 1'b1;
			end
		end
	end

	//==========================================================
	// Request output
	//==========================================================
	always_comb begin
		req_w.id = PID_BW'(id_r);
		req_w.linear = linear_r;
		req_w.bofs = bofs_r;
		req_w.aofs = aofs_r;
		// Retire rides on the final point only
		req_w.retire = retire_r && islast_w;
		req_w.islast = islast_w;
	end

	assign req.rdy = busy_r;
	assign req.data = req_w;

	// A stalled request keeps rdy and its payload
	a_req_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		req.rdy && !req.ack |=> req.rdy && $stable(req.data));

endmodule

/* rtl/memofs_stage.sv */
//==========================================================
// Memory offset stage
// Stride scaling, shuffle and linear fold over two registers
//==========================================================
module memofs_stage #(
	parameter int N_CFG = warp_addr_pkg::N_ICFG_DEFAULT,
	parameter int ABW = warp_addr_pkg::GLOBAL_ADDR_BW_DEFAULT
) (
	input  logic i_clk,
	input  logic i_arst_n,
	warp_req_if.dst req,
	input  warp_addr_pkg::cfg_t i_cfg,
	output logic o_dst_rdy,
	input  logic i_dst_ack,
	output warp_addr_pkg::res_t o_res
);

	localparam int VDIM = warp_addr_pkg::VDIM;
	localparam int DIM = warp_addr_pkg::DIM;
	localparam int WBW = warp_addr_pkg::WORK_BW;
	localparam int GABW = warp_addr_pkg::GLOBAL_ADDR_BW_DEFAULT;
	localparam int PID_BW = warp_addr_pkg::ID_BW;
	localparam int NCFG_BW = $clog2(N_CFG);

	// Stage 0 contents
	typedef struct packed {
		logic [NCFG_BW-1:0] id;
		logic [ABW-1:0] linear;
		logic [VDIM-1:0][WBW-1:0] bofs;
		logic retire;
		logic islast;
		logic [DIM-1:0][WBW-1:0] mofs;
	} s0_t;

	logic [VDIM-1:0][WBW-1:0] bofs_scl;
	logic [VDIM-1:0][WBW-1:0] aofs_scl;
	logic [DIM-1:0][WBW-1:0] mofs_w;
	s0_t s0_in;
	s0_t s0_out;
	logic s0_rdy;
	logic s0_ack;
	logic [ABW-1:0] linear_w;
	warp_addr_pkg::res_t res_w;

	//==========================================================
	// Input side
	//==========================================================
	// Offset times fraction, then shifted
	always_comb begin
		for (int i = 0; i < VDIM; i++) begin
			bofs_scl[i] = (req.data.bofs[i] * i_cfg.bstride_frac[i]) << i_cfg.bstride_shamt[i];
			aofs_scl[i] = (req.data.aofs[i] * i_cfg.astride_frac[i]) << i_cfg.astride_shamt[i];
		end
	end

	nd_shuf_accum u_saccum (
		.i_addend1(bofs_scl),
		.i_addend2(aofs_scl),
		.i_shuf1(i_cfg.bshuf),
		.i_shuf2(i_cfg.ashuf),
		.o_sum(mofs_w)
	);

	always_comb begin
		s0_in.id = NCFG_BW'(req.data.id);
		s0_in.linear = ABW'(req.data.linear);
		s0_in.bofs = req.data.bofs;
		s0_in.retire = req.data.retire;
		s0_in.islast = req.data.islast;
		s0_in.mofs = mofs_w;
	end

	rdyack_fwd_stage #(.payload_t(s0_t)) u_fwd0 (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_src_rdy(req.rdy),
		.o_src_ack(req.ack),
		.i_src_data(s0_in),
		.o_dst_rdy(s0_rdy),
		.i_dst_ack(s0_ack),
		.o_dst_data(s0_out)
	);

	//==========================================================
	// Linear fold
	//==========================================================
	// Row-major over mboundary, last dimension unscaled
	always_comb begin
		linear_w = s0_out.linear;
		for (int d = 0; d < DIM-1; d++) begin
			linear_w = linear_w + ABW'(s0_out.mofs[d]) * ABW'(i_cfg.mboundary[d+1]);
		end
		linear_w = linear_w + ABW'(s0_out.mofs[DIM-1]);
	end

	always_comb begin
		res_w.id = PID_BW'(s0_out.id);
		res_w.linear = GABW'(linear_w);
		res_w.bofs = s0_out.bofs;
		res_w.retire = s0_out.retire;
		res_w.islast = s0_out.islast;
	end

	rdyack_fwd_stage #(.payload_t(warp_addr_pkg::res_t)) u_fwd1 (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_src_rdy(s0_rdy),
		.o_src_ack(s0_ack),
		.i_src_data(res_w),
		.o_dst_rdy(o_dst_rdy),
		.i_dst_ack(i_dst_ack),
		.o_dst_data(o_res)
	);

endmodule

/* rtl/warp_addr_top.sv */
//==========================================================
// Warp memory port address generator, top level
//==========================================================
module warp_addr_top #(
	parameter int N_CFG = warp_addr_pkg::N_ICFG_DEFAULT,
	parameter int ABW = warp_addr_pkg::GLOBAL_ADDR_BW_DEFAULT,
	localparam int NCFG_BW = $clog2(N_CFG),
	localparam int VDIM = warp_addr_pkg::VDIM,
	localparam int DIM = warp_addr_pkg::DIM,
	localparam int WBW = warp_addr_pkg::WORK_BW
) (
	input  logic i_clk,
	input  logic i_arst_n,
	// Command
	input  logic i_cmd_rdy,
	output logic o_cmd_ack,
	input  logic [NCFG_BW-1:0] i_cmd_id,
	input  logic [ABW-1:0] i_cmd_linear,
	input  logic [VDIM-1:0][WBW-1:0] i_cmd_aofs,
	input  logic [VDIM-1:0][WBW-1:0] i_cmd_bcount,
	input  logic i_cmd_retire,
	// Configuration, held stable by the host
	input  logic [VDIM-1:0][warp_addr_pkg::STRIDE_FRAC_BW-1:0] i_cfg_bstride_frac,
	input  logic [VDIM-1:0][warp_addr_pkg::STRIDE_BW-1:0] i_cfg_bstride_shamt,
	input  logic [VDIM-1:0][warp_addr_pkg::STRIDE_FRAC_BW-1:0] i_cfg_astride_frac,
	input  logic [VDIM-1:0][warp_addr_pkg::STRIDE_BW-1:0] i_cfg_astride_shamt,
	input  logic [VDIM-1:0][warp_addr_pkg::DIM_BW-1:0] i_cfg_bshuf,
	input  logic [VDIM-1:0][warp_addr_pkg::DIM_BW-1:0] i_cfg_ashuf,
	input  logic [DIM-1:0][ABW-1:0] i_cfg_mboundary,
	// Result
	output logic o_res_rdy,
	input  logic i_res_ack,
	output logic [NCFG_BW-1:0] o_res_id,
	output logic [ABW-1:0] o_res_linear,
	output logic [VDIM-1:0][WBW-1:0] o_res_bofs,
	output logic o_res_retire,
	output logic o_res_islast
);

	localparam int GABW = warp_addr_pkg::GLOBAL_ADDR_BW_DEFAULT;

	warp_addr_pkg::cfg_t cfg;
	warp_addr_pkg::res_t res;
	warp_req_if req_link ();

	// Config packing
	assign cfg.bstride_frac = i_cfg_bstride_frac;
	assign cfg.bstride_shamt = i_cfg_bstride_shamt;
	assign cfg.astride_frac = i_cfg_astride_frac;
	assign cfg.astride_shamt = i_cfg_astride_shamt;
	assign cfg.bshuf = i_cfg_bshuf;
	assign cfg.ashuf = i_cfg_ashuf;
	for (genvar d = 0; d < DIM; d++) begin : g_mbnd
		assign cfg.mboundary[d] = GABW'(i_cfg_mboundary[d]);
	end

	warp_offset_looper #(.N_CFG(N_CFG)) u_looper (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_cmd_rdy(i_cmd_rdy),
		.o_cmd_ack(o_cmd_ack),
		.i_cmd_id(i_cmd_id),
		.i_cmd_linear(GABW'(i_cmd_linear)),
		.i_cmd_aofs(i_cmd_aofs),
		.i_cmd_bcount(i_cmd_bcount),
		.i_cmd_retire(i_cmd_retire),
		.req(req_link.src)
	);

	memofs_stage #(.N_CFG(N_CFG), .ABW(ABW)) u_memofs (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.req(req_link.dst),
		.i_cfg(cfg),
		.o_dst_rdy(o_res_rdy),
		.i_dst_ack(i_res_ack),
		.o_res(res)
	);

	// Result unpacking
	assign o_res_id = NCFG_BW'(res.id);
	assign o_res_linear = ABW'(res.linear);
	assign o_res_bofs = res.bofs;
	assign o_res_retire = res.retire;
	assign o_res_islast = res.islast;

endmodule

/* tb/warp_addr_tb.sv */
//==========================================================
// Warp address generator testbench
// Random commands and configs checked against a reference model
//==========================================================
module warp_addr_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int VDIM = warp_addr_pkg::VDIM;
	localparam int DIM = warp_addr_pkg::DIM;
	localparam int WBW = warp_addr_pkg::WORK_BW;
	localparam int FBW = warp_addr_pkg::STRIDE_FRAC_BW;
	localparam int SBW = warp_addr_pkg::STRIDE_BW;
	localparam int DBW = warp_addr_pkg::DIM_BW;
	localparam int NCFG = warp_addr_pkg::N_ICFG_DEFAULT;
	localparam int ABW = warp_addr_pkg::GLOBAL_ADDR_BW_DEFAULT;
	localparam int ID_BW = $clog2(NCFG);
	// Cycles any single wait may take
	localparam int WAIT_LIMIT = 2000;

	// Expected result of one walk point
	typedef struct packed {
		logic [ID_BW-1:0] id;
		logic [ABW-1:0] linear;
		logic [VDIM-1:0][WBW-1:0] bofs;
		logic retire;
		logic islast;
	} exp_t;

	logic clk;
	logic i_arst_n;
	logic i_cmd_rdy;
	logic o_cmd_ack;
	logic [ID_BW-1:0] i_cmd_id;
	logic [ABW-1:0] i_cmd_linear;
	logic [VDIM-1:0][WBW-1:0] i_cmd_aofs;
	logic [VDIM-1:0][WBW-1:0] i_cmd_bcount;
	logic i_cmd_retire;
	logic [VDIM-1:0][FBW-1:0] i_cfg_bstride_frac;
	logic [VDIM-1:0][SBW-1:0] i_cfg_bstride_shamt;
	logic [VDIM-1:0][FBW-1:0] i_cfg_astride_frac;
	logic [VDIM-1:0][SBW-1:0] i_cfg_astride_shamt;
	logic [VDIM-1:0][DBW-1:0] i_cfg_bshuf;
	logic [VDIM-1:0][DBW-1:0] i_cfg_ashuf;
	logic [DIM-1:0][ABW-1:0] i_cfg_mboundary;
	logic o_res_rdy;
	logic i_res_ack;
	logic [ID_BW-1:0] o_res_id;
	logic [ABW-1:0] o_res_linear;
	logic [VDIM-1:0][WBW-1:0] o_res_bofs;
	logic o_res_retire;
	logic o_res_islast;

	// Scoreboard and bookkeeping
	exp_t exp_q[$];
	int seed;
	int ack_pct;
	int err_cnt;
	int check_cnt;
	int test_err_base;
	int tests_run;
	int tests_failed;
	logic timed_out;

	warp_addr_top #(.N_CFG(NCFG), .ABW(ABW)) i_dut (
		.i_clk(clk),
		.i_arst_n(i_arst_n),
		.i_cmd_rdy(i_cmd_rdy),
		.o_cmd_ack(o_cmd_ack),
		.i_cmd_id(i_cmd_id),
		.i_cmd_linear(i_cmd_linear),
		.i_cmd_aofs(i_cmd_aofs),
		.i_cmd_bcount(i_cmd_bcount),
		.i_cmd_retire(i_cmd_retire),
		.i_cfg_bstride_frac(i_cfg_bstride_frac),
		.i_cfg_bstride_shamt(i_cfg_bstride_shamt),
		.i_cfg_astride_frac(i_cfg_astride_frac),
		.i_cfg_astride_shamt(i_cfg_astride_shamt),
		.i_cfg_bshuf(i_cfg_bshuf),
		.i_cfg_ashuf(i_cfg_ashuf),
		.i_cfg_mboundary(i_cfg_mboundary),
		.o_res_rdy(o_res_rdy),
		.i_res_ack(i_res_ack),
		.o_res_id(o_res_id),
		.o_res_linear(o_res_linear),
		.o_res_bofs(o_res_bofs),
		.o_res_retire(o_res_retire),
		.o_res_islast(o_res_islast)
	);

	// 100 ns clock
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//==========================================================
	// Reference model
	//==========================================================
	function automatic int rand_range(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// Offset times fraction and shifted, kept to the work width
	function automatic logic [WBW-1:0] scale(input logic [WBW-1:0] ofs,
		input logic [FBW-1:0] frac, input logic [SBW-1:0] shamt);
		longint prod;
		prod = longint'(ofs) * longint'(frac);
		prod = prod << shamt;
		return WBW'(prod % (longint'(1) << WBW));
	endfunction

	// Expand an accepted command into its walk with bofs[0] fastest
	task automatic expand_cmd();
		int cnt [VDIM];
		int total;
		int rem;
		longint mofs [DIM];
		longint lin;
		exp_t e;
		for (int d = 0; d < VDIM; d++) begin
			cnt[d] = (i_cmd_bcount[d] == '0) ? 1 : int'(i_cmd_bcount[d]);
		end
		total = cnt[0] * cnt[1];
		for (int idx = 0; idx < total; idx++) begin
			rem = idx;
			for (int d = 0; d < VDIM; d++) begin
				e.bofs[d] = WBW'(rem % cnt[d]);
				rem = rem / cnt[d];
			end
			for (int d = 0; d < DIM; d++) begin
				mofs[d] = 0;
			end
			// Route scaled entries to the memory dimension they name
			for (int i = 0; i < VDIM; i++) begin
				if (int'(i_cfg_bshuf[i]) < DIM) begin
					mofs[i_cfg_bshuf[i]] += scale(e.bofs[i], i_cfg_bstride_frac[i],
						i_cfg_bstride_shamt[i]);
				end
				if (int'(i_cfg_ashuf[i]) < DIM) begin
					mofs[i_cfg_ashuf[i]] += scale(i_cmd_aofs[i], i_cfg_astride_frac[i],
						i_cfg_astride_shamt[i]);
				end
			end
			// Row-major fold with the last dimension unscaled
			lin = longint'(i_cmd_linear);
			for (int d = 0; d < DIM; d++) begin
				mofs[d] = mofs[d] % (longint'(1) << WBW);
				if (d < DIM-1) begin
					lin += mofs[d] * longint'(i_cfg_mboundary[d+1]);
				end else begin
					lin += mofs[d];
				end
			end
			e.linear = ABW'(lin % (longint'(1) << ABW));
			e.id = i_cmd_id;
			e.islast = (idx == total-1);
			e.retire = i_cmd_retire && e.islast;
			exp_q.push_back(e);
		end
	endtask

	//==========================================================
	// Checking
	//==========================================================
	task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic check_result();
		exp_t e;
		check_eq("result while one is expected", exp_q.size() != 0, 1);
		if (exp_q.size() != 0) begin
			e = exp_q.pop_front();
			check_eq("result id", o_res_id, e.id);
			check_eq("result linear", o_res_linear, e.linear);
			check_eq("result bofs[0]", o_res_bofs[0], e.bofs[0]);
			check_eq("result bofs[1]", o_res_bofs[1], e.bofs[1]);
			check_eq("result retire", o_res_retire, e.retire);
			check_eq("result islast", o_res_islast, e.islast);
		end
	endtask

	// Handshakes seen just after the falling edge and before the transfer edge
	task automatic observe();
		if (o_res_rdy && i_res_ack) begin
			check_result();
		end
		if (i_cmd_rdy && o_cmd_ack) begin
			// Looper idle means at most the two stage registers hold items
			check_eq("items in flight at command accept", exp_q.size() <= 2, 1);
			expand_cmd();
		end
	endtask

	//==========================================================
	// Stimulus
	//==========================================================
	task automatic cycle_begin();
		@(negedge clk);
		// Result ack only while a result is offered
		i_res_ack = o_res_rdy && (rand_range(100) < ack_pct);
	endtask

	task automatic cycle_end();
		#1;
		observe();
	endtask

	task automatic idle_step();
		cycle_begin();
		i_cmd_rdy = 1'b0;
		cycle_end();
	endtask

	// Mode 0 gives identity maps, mode 1 random maps and mode 2 one shared dimension
	task automatic set_cfg(input int mode);
		int dim;
		cycle_begin();
		i_cmd_rdy = 1'b0;
		dim = rand_range(DIM);
		for (int i = 0; i < VDIM; i++) begin
			i_cfg_bstride_frac[i] = FBW'(rand_range(1 << FBW));
			i_cfg_bstride_shamt[i] = SBW'(rand_range(1 << SBW));
			i_cfg_astride_frac[i] = FBW'(rand_range(1 << FBW));
			i_cfg_astride_shamt[i] = SBW'(rand_range(1 << SBW));
			if (mode == 0) begin
				i_cfg_bshuf[i] = DBW'(i);
				i_cfg_ashuf[i] = DBW'(i);
			end else if (mode == 1) begin
				i_cfg_bshuf[i] = DBW'(rand_range(DIM));
				i_cfg_ashuf[i] = DBW'(rand_range(DIM));
			end else begin
				i_cfg_bshuf[i] = DBW'(dim);
				i_cfg_ashuf[i] = DBW'(dim);
			end
		end
		for (int d = 0; d < DIM; d++) begin
			i_cfg_mboundary[d] = ABW'($random(seed));
		end
		cycle_end();
	endtask

	// One random command held until acknowledged and followed by a short gap
	task automatic send_cmd(input int max_bcount);
		logic [ID_BW-1:0] id;
		logic [ABW-1:0] linear;
		logic [VDIM-1:0][WBW-1:0] aofs;
		logic [VDIM-1:0][WBW-1:0] bcount;
		logic retire;
		logic acked;
		int waited;
		id = ID_BW'(rand_range(NCFG));
		linear = ABW'($random(seed));
		retire = 1'(rand_range(2));
		for (int d = 0; d < VDIM; d++) begin
			aofs[d] = WBW'($random(seed));
			bcount[d] = (max_bcount == 1) ? WBW'(1) : WBW'(rand_range(max_bcount + 1));
		end
		acked = 1'b0;
		waited = 0;
		while (!acked && !timed_out) begin
			cycle_begin();
			i_cmd_rdy = 1'b1;
			i_cmd_id = id;
			i_cmd_linear = linear;
			i_cmd_aofs = aofs;
			i_cmd_bcount = bcount;
			i_cmd_retire = retire;
			cycle_end();
			acked = o_cmd_ack;
			waited++;
			if (!acked && waited >= WAIT_LIMIT) begin
				timed_out = 1'b1;
				$display("Timeout: command not acknowledged within %0d cycles", WAIT_LIMIT);
			end
		end
		repeat (rand_range(3)) idle_step();
	endtask

	// Wait until every expected result has arrived
	task automatic drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && !timed_out) begin
			idle_step();
			waited++;
			if (exp_q.size() != 0 && waited >= WAIT_LIMIT) begin
				timed_out = 1'b1;
				$display("Timeout: %0d results still missing after %0d cycles",
					exp_q.size(), WAIT_LIMIT);
			end
		end
		// Quiet cycles catch any extra result
		repeat (3) idle_step();
		// Nothing may still be offered once the walk is done
		check_eq("o_res_rdy after drain", o_res_rdy, 0);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (err_cnt != test_err_base) begin
			tests_failed++;
			$display("Test %-14s FAILED with %0d errors", name, err_cnt - test_err_base);
		end else begin
			$display("Test %-14s ok", name);
		end
		test_err_base = err_cnt;
	endtask

	//==========================================================
	// Test sequence
	//==========================================================
	initial begin
		seed = 32'h0196dc44;
		err_cnt = 0;
		check_cnt = 0;
		test_err_base = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		ack_pct = 100;
		i_arst_n = 1'b0;
		i_cmd_rdy = 1'b0;
		i_cmd_id = '0;
		i_cmd_linear = '0;
		i_cmd_aofs = '0;
		i_cmd_bcount = '0;
		i_cmd_retire = 1'b0;
		i_cfg_bstride_frac = '0;
		i_cfg_bstride_shamt = '0;
		i_cfg_astride_frac = '0;
		i_cfg_astride_shamt = '0;
		i_cfg_bshuf = '0;
		i_cfg_ashuf = '0;
		i_cfg_mboundary = '0;
		i_res_ack = 1'b0;

		// Reset held over two rising edges
		repeat (2) @(posedge clk);
		#1;
		check_eq("o_cmd_ack in reset", o_cmd_ack, 0);
		check_eq("o_res_rdy in reset", o_res_rdy, 0);
		@(negedge clk);
		i_arst_n = 1'b1;
		repeat (4) begin
			idle_step();
			check_eq("o_cmd_ack after reset", o_cmd_ack, 0);
			check_eq("o_res_rdy after reset", o_res_rdy, 0);
		end
		finish_test("reset state");

		set_cfg(0);
		repeat (20) send_cmd(1);
		drain();
		finish_test("single point");

		ack_pct = 80;
		set_cfg(0);
		repeat (15) send_cmd(5);
		drain();
		finish_test("walk order");

		ack_pct = 100;
		for (int r = 0; r < 6; r++) begin
			set_cfg((r == 0) ? 2 : 1);
			repeat (6) send_cmd(3);
			drain();
		end
		finish_test("shuffle fold");

		// Sparse result acks fill both stage registers
		ack_pct = 25;
		for (int r = 0; r < 3; r++) begin
			set_cfg(1);
			repeat (10) send_cmd(4);
			drain();
		end
		finish_test("back-pressure");

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, check_cnt, err_cnt);
		if (err_cnt == 0 && tests_failed == 0 && !timed_out) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* flist.f */
rtl/warp_addr_pkg.sv
rtl/warp_req_if.sv
rtl/rdyack_fwd_stage.sv
rtl/nd_shuf_accum.sv
rtl/warp_offset_looper.sv
rtl/memofs_stage.sv
rtl/warp_addr_top.sv
tb/warp_addr_tb.sv

/* Makefile */
SIM       ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= warp_addr_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Some tests failed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)

run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
